// File: Makefile
TOP = tb_bp

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q '\*\*\* PASSED \*\*\*' run.log

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only --top-module bp_top \
		src/bp_pkg.sv src/bp_ifs.sv src/history_table.sv \
		src/branch_predictor.sv src/bp_csr.sv src/bp_top.sv

clean:
	rm -rf obj_dir run.log

// File: src/bp_csr.sv
`default_nettype none

module bp_csr
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          csr_we,
	input  logic [1:0]                    csr_addr,
	input  logic [bp_pkg::cnt_width-1:0]  csr_wdata,
	output logic [bp_pkg::cnt_width-1:0]  csr_rdata,
	bp_event_if.sink                      ev
);
	import bp_pkg::*;

	bp_mode_t             mode_q;
	logic [cnt_width-1:0] branches_q;
	logic [cnt_width-1:0] mispredicts_q;
	logic [cnt_width-1:0] hits_q;

	assign ev.mode = mode_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mode_q        <= mode_dynamic;
			branches_q    <= '0;
			mispredicts_q <= '0;
			hits_q        <= '0;
		end
		else
		begin
			if (csr_we && (csr_addr == csr_addr_mode))
				mode_q <= bp_mode_t'(csr_wdata[1:0]);

			// a write clears, and beats an increment in the same cycle
			if (csr_we && (csr_addr == csr_addr_branches))
				branches_q <= '0;
			else if (ev.resolved)
				branches_q <= branches_q + 1'b1;

			if (csr_we && (csr_addr == csr_addr_mispredicts))
				mispredicts_q <= '0;
			else if (ev.resolved && ev.mispredict)
				mispredicts_q <= mispredicts_q + 1'b1;

			if (csr_we && (csr_addr == csr_addr_hits))
				hits_q <= '0;
			else if (ev.resolved && ev.was_hit)
				hits_q <= hits_q + 1'b1;  // wraps
		end
	end

	// read mux
	always_comb
	begin
		case (csr_addr)
			csr_addr_mode:        csr_rdata = cnt_width'(mode_q);
			csr_addr_branches:    csr_rdata = branches_q;
			csr_addr_mispredicts: csr_rdata = mispredicts_q;
			default:              csr_rdata = hits_q;
		endcase
	end

endmodule

`default_nettype wire

// File: src/bp_ifs.sv
`default_nettype none

// predictor <-> history table
interface bp_table_if;
	import bp_pkg::*;

	logic [pc_width-1:0]    lookup_tag;  // PC+4 of the branch in IF
	logic                   wr_en;
	logic                   wr_alloc;    // new entry at the replacement pointer
	logic [index_width-1:0] wr_index;    // entry to update when not allocating
	logic [pc_width-1:0]    wr_tag;
	logic                   wr_taken;

	// lookup result, combinational from lookup_tag
	logic                   hit;
	logic [index_width-1:0] hit_index;
	bp_entry_t              hit_entry;

	modport predictor
	(
		output lookup_tag, wr_en, wr_alloc, wr_index, wr_tag, wr_taken,
		input  hit, hit_index, hit_entry
	);

	modport store
	(
		input  lookup_tag, wr_en, wr_alloc, wr_index, wr_tag, wr_taken,
		output hit, hit_index, hit_entry
	);
endinterface

// predictor events -> counters, policy back to the predictor
interface bp_event_if;
	import bp_pkg::*;

	logic     resolved;    // one pulse per branch resolved at ID
	logic     mispredict;
	logic     was_hit;
	bp_mode_t mode;

	modport source (output resolved, mispredict, was_hit, input mode);
	modport sink   (input resolved, mispredict, was_hit, output mode);
endinterface

`default_nettype wire

// File: src/bp_pkg.sv
`default_nettype none

package bp_pkg;

	// datapath widths
	localparam int pc_width    = 32;
	localparam int table_depth = 16;
	localparam int index_width = 4;   // log2 of table_depth
	localparam int cnt_width   = 16;  // event counters and register data

	// prediction policy, encoding 3 falls back to dynamic
	typedef enum logic [1:0]
	{
		mode_dynamic          = 2'd0,
		mode_static_taken     = 2'd1,
		mode_static_not_taken = 2'd2
	} bp_mode_t;

	// register map of bp_csr
	localparam logic [1:0] csr_addr_mode        = 2'd0;
	localparam logic [1:0] csr_addr_branches    = 2'd1;
	localparam logic [1:0] csr_addr_mispredicts = 2'd2;
	localparam logic [1:0] csr_addr_hits        = 2'd3;

	// one history entry
	// the tag is the branch's PC+4, the same value the pipeline hands over at IF
	typedef struct packed
	{
		logic                valid;
		logic [pc_width-1:0] tag;
		logic                taken;  // last resolved outcome
	} bp_entry_t;

endpackage

`default_nettype wire

// File: src/bp_top.sv
`default_nettype none

module bp_top
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          branch_if,
	input  logic                          branch_id,
	input  logic                          stall,
	input  logic                          jump_or_not,
	input  logic [bp_pkg::pc_width-1:0]   pc_add_4,
	input  logic [bp_pkg::pc_width-1:0]   pc_add_imm,
	output logic [bp_pkg::pc_width-1:0]   pc_out,
	output logic                          predict_jump,
	output logic                          correct,
	input  logic                          csr_we,
	input  logic [1:0]                    csr_addr,
	input  logic [bp_pkg::cnt_width-1:0]  csr_wdata,
	output logic [bp_pkg::cnt_width-1:0]  csr_rdata
);

	bp_table_if tbl_if ();
	bp_event_if ev_if ();

	// tag/taken store
	history_table u_table
	(
		.clk   (clk),
		.rst_n (rst_n),
		.tbl   (tbl_if.store)
	);

	branch_predictor u_predictor
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.branch_if    (branch_if),
		.branch_id    (branch_id),
		.stall        (stall),
		.jump_or_not  (jump_or_not),
		.pc_add_4     (pc_add_4),
		.pc_add_imm   (pc_add_imm),
		.pc_out       (pc_out),
		.predict_jump (predict_jump),
		.correct      (correct),
		.tbl          (tbl_if.predictor),
		.ev           (ev_if.source)
	);

	// policy and event counters
	bp_csr u_csr
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.csr_we    (csr_we),
		.csr_addr  (csr_addr),
		.csr_wdata (csr_wdata),
		.csr_rdata (csr_rdata),
		.ev        (ev_if.sink)
	);

endmodule

`default_nettype wire

// File: src/branch_predictor.sv
`default_nettype none

module branch_predictor
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         branch_if,
	input  logic                         branch_id,
	input  logic                         stall,
	input  logic                         jump_or_not,  // true outcome at ID
	input  logic [bp_pkg::pc_width-1:0]  pc_add_4,
	input  logic [bp_pkg::pc_width-1:0]  pc_add_imm,
	output logic [bp_pkg::pc_width-1:0]  pc_out,
	output logic                         predict_jump,
	output logic                         correct,
	bp_table_if.predictor                tbl,
	bp_event_if.source                   ev
);
	import bp_pkg::*;

	// IF-to-ID holding registers
	logic [pc_width-1:0]    pc4_q;
	logic [pc_width-1:0]    imm_q;
	logic                   pred_q;
	logic                   hit_q;
	logic [index_width-1:0] idx_q;

	logic if_cycle;
	logic id_cycle;
	logic guess;     // prediction for the branch now in IF
	logic match;     // held prediction agrees with the outcome

	assign if_cycle = branch_if && !stall;
	assign id_cycle = branch_id && !stall && !branch_if;  // IF wins if both are set

	assign tbl.lookup_tag = pc_add_4;

	// policy select
	always_comb
	begin
		case (ev.mode)
			mode_static_taken:     guess = 1'b1;
			mode_static_not_taken: guess = 1'b0;
			default:               guess = tbl.hit ? tbl.hit_entry.taken : 1'b1;  // miss -> taken
		endcase
	end

	assign predict_jump = if_cycle ? guess : pred_q;
	assign match        = (pred_q == jump_or_not);

	// next fetch PC and resolution
	always_comb
	begin
		pc_out  = pc_add_4;
		correct = 1'b1;
		if (if_cycle)
		begin
			pc_out = guess ? pc_add_imm : pc_add_4;
		end
		else if (id_cycle)
		begin
			correct = match;
			if (match)
			begin
				// continue past the path already fetched
				pc_out = pred_q ? imm_q + pc_width'(4) : pc4_q + pc_width'(4);
			end
			else
			begin
				pc_out = pred_q ? pc4_q : imm_q;  // redirect to the other target
			end
		end
	end

	// table write at ID, in every mode
	assign tbl.wr_en    = id_cycle;
	assign tbl.wr_alloc = !hit_q;
	assign tbl.wr_index = idx_q;
	assign tbl.wr_tag   = pc4_q;
	assign tbl.wr_taken = jump_or_not;

	// event strobes for the counters
	assign ev.resolved   = id_cycle;
	assign ev.mispredict = id_cycle && !match;
	assign ev.was_hit    = id_cycle && hit_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc4_q  <= '0;
			imm_q  <= '0;
			pred_q <= 1'b0;
			hit_q  <= 1'b0;
			idx_q  <= '0;
		end
		else if (if_cycle)
		begin
			pc4_q  <= pc_add_4;
			imm_q  <= pc_add_imm;
			pred_q <= guess;
			hit_q  <= tbl.hit;
			idx_q  <= tbl.hit_index;
		end
	end

endmodule

`default_nettype wire

// File: src/history_table.sv
`default_nettype none

module history_table
(
	input  logic         clk,
	input  logic         rst_n,
	bp_table_if.store    tbl
);
	import bp_pkg::*;

	bp_entry_t              entries [table_depth];
	logic [index_width-1:0] rr_ptr;  // round-robin replacement pointer

	logic                   hit;
	logic [index_width-1:0] hit_index;

	// parallel compare against every valid entry
	always_comb
	begin
		hit       = 1'b0;
		hit_index = '0;
		// walk downward so the lowest matching index is the one left standing
		for (int i = table_depth - 1; i >= 0; i--)
		begin
			if (entries[i].valid && (entries[i].tag == tbl.lookup_tag))
			begin
				hit       = 1'b1;
				hit_index = index_width'(i);
			end
		end
	end

	assign tbl.hit       = hit;
	assign tbl.hit_index = hit_index;
	assign tbl.hit_entry = entries[hit_index];  // shows entry 0 on a miss

	// valid bits, replacement pointer and payload
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rr_ptr <= '0;
			for (int i = 0; i < table_depth; i++)
			begin
				entries[i].valid <= 1'b0;
			end
		end
		else if (tbl.wr_en)
		begin
			if (tbl.wr_alloc)
			begin
				entries[rr_ptr].valid <= 1'b1;
				entries[rr_ptr].tag   <= tbl.wr_tag;
				entries[rr_ptr].taken <= tbl.wr_taken;
				rr_ptr                <= rr_ptr + 1'b1;  // wraps after 15
			end
			else
			begin
				entries[tbl.wr_index].taken <= tbl.wr_taken;  // update in place
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_bp.sv
`default_nettype none

module tb_bp;
	timeunit 1ns;
	timeprecision 1ps;
	import bp_pkg::*;

	typedef struct packed
	{
		logic [pc_width-1:0]  pc;
		logic                 pred;
		logic                 ok;
		logic [cnt_width-1:0] rdata;
	} expect_t;

	logic                 clk;
	logic                 rst_n;
	logic                 branch_if, branch_id, stall, jump_or_not;
	logic [pc_width-1:0]  pc_add_4, pc_add_imm, pc_out;
	logic                 predict_jump, correct;
	logic                 csr_we;
	logic [1:0]           csr_addr;
	logic [cnt_width-1:0] csr_wdata, csr_rdata;

	// reference model state
	logic                 m_valid [table_depth];
	logic [pc_width-1:0]  m_tag [table_depth];
	logic                 m_taken [table_depth];
	int                   m_ptr;
	logic [1:0]           m_mode;
	logic [cnt_width-1:0] m_branches, m_misses, m_hits;
	logic [pc_width-1:0]  h_pc4, h_imm;  // what IF handed to ID
	logic                 h_pred, h_hit;
	int                   h_idx;

	logic [31:0]          rng = 32'd61072;
	logic                 random_writes = 1'b0;

	tb_clock clock0 (.clk(clk), .rst_n(rst_n));

	bp_top dut0 (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
			stop_run($sformatf("FAILED %s expected %h got %h", name, expected, actual));
	endtask

	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// lowest matching index or -1 on a miss
	function automatic int find_tag(input logic [pc_width-1:0] tag);
		for (int i = 0; i < table_depth; i++)
			if (m_valid[i] && m_tag[i] == tag)
				return i;
		return -1;
	endfunction

	// outputs expected for the inputs now on the pins
	function automatic expect_t reference_outputs();
		expect_t e;
		int      idx;
		logic    guess;
		idx = find_tag(pc_add_4);
		guess = (idx >= 0) ? m_taken[idx] : 1'b1;  // unknown branch goes taken
		if (m_mode == mode_static_taken)
			guess = 1'b1;
		else if (m_mode == mode_static_not_taken)
			guess = 1'b0;
		e.pc = pc_add_4;
		e.ok = 1'b1;
		e.pred = (branch_if && !stall) ? guess : h_pred;
		if (branch_if && !stall)
			e.pc = guess ? pc_add_imm : pc_add_4;
		else if (branch_id && !stall)
		begin
			e.ok = (h_pred == jump_or_not);
			if (e.ok)
				e.pc = (h_pred ? h_imm : h_pc4) + 32'd4;
			else
				e.pc = h_pred ? h_pc4 : h_imm;  // the path not taken
		end
		case (csr_addr)
			csr_addr_mode:        e.rdata = cnt_width'(m_mode);
			csr_addr_branches:    e.rdata = m_branches;
			csr_addr_mispredicts: e.rdata = m_misses;
			default:              e.rdata = m_hits;
		endcase
		return e;
	endfunction

	// compare at the falling edge, then step the model across the next rising edge
	always @(negedge clk)
	begin
		expect_t e;
		int      idx;
		e = reference_outputs();
		idx = find_tag(pc_add_4);
		if (rst_n !== 1'b1)
		begin
			m_valid = '{default: 1'b0};
			m_ptr = 0;
			m_mode = mode_dynamic;
			{m_branches, m_misses, m_hits} = '0;
			{h_pc4, h_imm, h_pred, h_hit} = '0;
		end
		else
		begin
			check_value("pc_out", e.pc, pc_out);
			check_value("predict_jump", 32'(e.pred), 32'(predict_jump));
			check_value("correct", 32'(e.ok), 32'(correct));
			check_value("csr_rdata", 32'(e.rdata), 32'(csr_rdata));
			if (branch_if && !stall)
			begin
				{h_pc4, h_imm, h_pred, h_hit} = {pc_add_4, pc_add_imm, e.pred, idx >= 0};
				h_idx = idx;
			end
			else if (branch_id && !stall)
			begin
				m_branches = m_branches + 1'b1;
				m_misses = m_misses + cnt_width'(!e.ok);
				m_hits = m_hits + cnt_width'(h_hit);
				if (h_hit)
					m_taken[h_idx] = jump_or_not;
				else
				begin
					m_valid[m_ptr] = 1'b1;
					m_tag[m_ptr] = h_pc4;
					m_taken[m_ptr] = jump_or_not;
					m_ptr = (m_ptr + 1) % table_depth;
				end
			end
			// a register write lands after the increments, so a clear wins
			if (csr_we)
			begin
				case (csr_addr)
					csr_addr_mode:        m_mode = csr_wdata[1:0];
					csr_addr_branches:    m_branches = '0;
					csr_addr_mispredicts: m_misses = '0;
					default:              m_hits = '0;
				endcase
			end
		end
	end

	// one clock of stimulus driven just after the rising edge
	task automatic cycle(input logic bif, input logic bid, input logic stl, input logic jmp,
		input logic [pc_width-1:0] pc4, input logic [pc_width-1:0] imm);
		logic [31:0] r;
		r = rand32();
		@(posedge clk);
		branch_if   <= bif;
		branch_id   <= bid;
		stall       <= stl;
		jump_or_not <= jmp;
		pc_add_4    <= pc4;
		pc_add_imm  <= imm;
		csr_we      <= random_writes && !stl && r[7:4] == 4'd0;
		csr_addr    <= r[1:0];  // random read port address
		csr_wdata   <= r[31:16];
	endtask

	// idle or stalled cycle with strobes only under stall
	task automatic filler();
		logic [31:0] r;
		r = rand32();
		cycle(r[0] & r[1], r[0] & r[2], r[0], r[3], rand32(), rand32());
	endtask

	// IF, then ID one to three cycles later
	task automatic run_branch(input logic [pc_width-1:0] pc4, input logic taken);
		int gap;
		gap = int'(rand32() % 32'd3);
		cycle(1'b1, 1'b0, 1'b0, 1'b0, pc4, rand32() & ~32'h3);
		repeat (gap)
			filler();
		cycle(1'b0, 1'b1, 1'b0, taken, rand32(), rand32());
	endtask

	task automatic expect_branch(input logic [pc_width-1:0] pc4, input logic taken,
		input logic guess);
		logic [pc_width-1:0] imm;
		logic [pc_width-1:0] next_pc;
		imm = pc4 + 32'h400;
		next_pc = (guess == taken) ? (guess ? imm : pc4) + 32'd4 : (guess ? pc4 : imm);
		cycle(1'b1, 1'b0, 1'b0, 1'b0, pc4, imm);
		@(negedge clk);
		check_value("predict_jump", 32'(guess), 32'(predict_jump));
		check_value("pc_out", guess ? imm : pc4, pc_out);
		cycle(1'b0, 1'b1, 1'b0, taken, 32'h0, 32'h0);
		@(negedge clk);
		check_value("correct", 32'(guess == taken), 32'(correct));
		check_value("pc_out", next_pc, pc_out);
	endtask

	// register write, or read with a known value, on an otherwise idle cycle
	task automatic reg_access(input logic we, input logic [1:0] addr,
		input logic [cnt_width-1:0] value);
		cycle(1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
		csr_we    <= we;
		csr_addr  <= addr;
		csr_wdata <= value;
		@(negedge clk);
		if (!we)
			check_value("csr_rdata", 32'(value), 32'(csr_rdata));
	endtask

	initial
	begin
		int waited;
		{branch_if, branch_id, stall, jump_or_not, csr_we} <= '0;
		{pc_add_4, pc_add_imm} <= '0;
		csr_addr  <= csr_addr_mode;
		csr_wdata <= '0;
		waited = 0;
		while (rst_n !== 1'b1)
		begin
			@(posedge clk);
			waited++;
			if (waited > 10)
				stop_run("reset was never released");
		end

		for (int a = 0; a < 4; a++)
			reg_access(1'b0, 2'(a), '0);
		check_value("predict_jump", 32'd0, 32'(predict_jump));

		// learn, hit, update in place
		expect_branch(32'h1000, 1'b0, 1'b1);
		expect_branch(32'h1000, 1'b1, 1'b0);
		expect_branch(32'h1000, 1'b0, 1'b1);
		expect_branch(32'h2000, 1'b1, 1'b1);
		for (int i = 0; i < 15; i++)
			expect_branch(32'h3000 + 32'(i) * 32'd16, 1'b1, 1'b1);
		expect_branch(32'h1000, 1'b0, 1'b1);  // entry 0 was taken over
		expect_branch(32'h1000, 1'b1, 1'b0);

		// static modes while the table keeps training
		reg_access(1'b1, csr_addr_mode, cnt_width'(mode_static_not_taken));
		expect_branch(32'h5000, 1'b1, 1'b0);
		reg_access(1'b1, csr_addr_mode, cnt_width'(mode_static_taken));
		expect_branch(32'h6000, 1'b0, 1'b1);
		reg_access(1'b1, csr_addr_mode, cnt_width'(mode_dynamic));
		expect_branch(32'h5000, 1'b0, 1'b1);
		expect_branch(32'h6000, 1'b1, 1'b0);

		reg_access(1'b1, csr_addr_branches, 16'hffff);
		reg_access(1'b1, csr_addr_hits, 16'hffff);
		expect_branch(32'h6000, 1'b1, 1'b1);
		reg_access(1'b0, csr_addr_branches, 16'd1);
		reg_access(1'b0, csr_addr_hits, 16'd1);

		// random traffic over 24 tags which overflows the table
		random_writes = 1'b1;
		for (int n = 0; n < 400; n++)
		begin
			if (rand32() % 32'd5 == 32'd0)
				filler();
			else
				run_branch(32'h8000 + (rand32() % 32'd24) * 32'd4, rand32() > 32'h6000_0000);
		end
		random_writes = 1'b0;
		repeat (2)
			@(negedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock
(
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// reset low over the first three rising edges
	initial
	begin
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: vlog.f
src/bp_pkg.sv
src/bp_ifs.sv
src/history_table.sv
src/branch_predictor.sv
src/bp_csr.sv
src/bp_top.sv
testbench/tb_clock.sv
testbench/tb_bp.sv
